/* all.f */
+incdir+tests
logic/isaPkg.sv
logic/datapathPkg.sv
logic/registerBank.sv
logic/alu.sv
logic/datapath.sv
logic/controlSequencer.sv
logic/stepCounter.sv
logic/apbHostPort.sv
logic/cpuCore.sv
tests/cpuCoreTb.sv

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
  input  isaPkg::opcodeE aluOp,
  input  logic [31:0]    yVal,
  input  logic [31:0]    busVal,
  output logic [63:0]    result
);

  logic signed [31:0] ySigned;
  logic signed [31:0] busSigned;
  logic signed [63:0] product;
  logic [31:0]        quotient;
  logic [31:0]        remainder;

  assign ySigned   = yVal;
  assign busSigned = busVal;
  assign product   = 64'(ySigned) * 64'(busSigned);

  always_comb begin
    if (busVal == '0) begin
      quotient  = '1;    // divide by zero
      remainder = yVal;
    end else if (yVal == 32'h8000_0000 && busVal == '1) begin
      // most negative over -1 wraps back to itself
      quotient  = yVal;
      remainder = '0;
    end else begin
      quotient  = ySigned / busSigned;
      remainder = ySigned % busSigned;
    end
  end

  always_comb begin
    result = '0;  // upper half stays zero outside mul/div
    case (aluOp)
      isaPkg::OP_ADD, isaPkg::OP_ADDI: begin
        result[31:0] = yVal + busVal;
      end
      isaPkg::OP_SUB: begin
        result[31:0] = yVal - busVal;
      end
      isaPkg::OP_AND, isaPkg::OP_ANDI: begin
        result[31:0] = yVal & busVal;
      end
      isaPkg::OP_OR, isaPkg::OP_ORI: begin
        result[31:0] = yVal | busVal;
      end
      isaPkg::OP_SHL: begin
        result[31:0] = yVal << busVal[4:0];
      end
      isaPkg::OP_SHR: begin
        result[31:0] = yVal >> busVal[4:0];  // logical
      end
      isaPkg::OP_MUL: begin
        result = product;
      end
      isaPkg::OP_DIV: begin
        result = {remainder, quotient};
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* logic/apbHostPort.sv */
`timescale 1ns/1ps

module apbHostPort (
  input  logic                clock,
  input  logic                rstN,
  input  datapathPkg::apbReqT apbReq,
  output datapathPkg::apbRspT apbRsp,
  input  logic                busy,
  input  logic [15:0]         retiredCount,
  input  logic [31:0]         outPortData,
  output logic                instrValid,
  output isaPkg::instrU       instr,
  output logic [31:0]         inPortData
);

  logic access;
  logic stall;
  logic complete;
  logic addrError;
  logic writeOk;

  assign access   = apbReq.psel & apbReq.penable;
  assign stall    = apbReq.pwrite && (apbReq.paddr == datapathPkg::ADDR_INSTR) && busy;
  assign complete = access & ~stall;
  assign writeOk  = complete & apbReq.pwrite & ~addrError;

  always_comb begin
    case (apbReq.paddr)
      datapathPkg::ADDR_INSTR, datapathPkg::ADDR_INPORT:   addrError = !apbReq.pwrite;
      datapathPkg::ADDR_OUTPORT, datapathPkg::ADDR_STATUS: addrError = apbReq.pwrite;
      default:                                             addrError = 1'b1;
    endcase
  end

  always_comb begin
    apbRsp.pready  = complete;
    apbRsp.pslverr = complete & addrError;
    apbRsp.prdata  = '0;
    if (complete && !apbReq.pwrite) begin
      case (apbReq.paddr)
        datapathPkg::ADDR_OUTPORT: apbRsp.prdata = outPortData;
        datapathPkg::ADDR_STATUS:  apbRsp.prdata = {retiredCount, 15'd0, busy};
        default:                   apbRsp.prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      instrValid <= 1'b0;
      instr      <= '0;
      inPortData <= '0;
    end else begin
      instrValid <= writeOk && (apbReq.paddr == datapathPkg::ADDR_INSTR);  // one cycle
      if (writeOk && apbReq.paddr == datapathPkg::ADDR_INSTR) begin
        instr <= apbReq.pwdata;
      end
      if (writeOk && apbReq.paddr == datapathPkg::ADDR_INPORT) begin
        inPortData <= apbReq.pwdata;
      end
    end
  end

endmodule

/* logic/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer (
  input  logic                     clock,
  input  logic                     rstN,
  input  logic                     instrValid,
  input  isaPkg::instrU            instr,
  input  logic [2:0]               stepNum,
  output datapathPkg::controlWordT ctrl,
  output logic                     stepClear,
  output logic                     retire,
  output logic                     busy
);

  typedef enum logic {
    IDLE,
    EXEC
  } stateE;

  stateE          state;
  isaPkg::opcodeE op;
  logic           iForm;
  logic           mulDiv;
  logic [2:0]     lastStep;
  logic           onLastStep;

  function automatic datapathPkg::busSrcE regSrc(input logic [3:0] idx);
    return datapathPkg::busSrcE'({1'b0, idx});
  endfunction

  function automatic logic [15:0] regSel(input logic [3:0] idx);
    return 16'd1 << idx;
  endfunction

  assign op     = instr.r.opcode;  // same bits in both views
  assign iForm  = isaPkg::isIFormat(op);
  assign mulDiv = op inside {isaPkg::OP_MUL, isaPkg::OP_DIV};

  always_comb begin
    case (op)
      isaPkg::OP_MFHI, isaPkg::OP_MFLO, isaPkg::OP_IN, isaPkg::OP_OUT: lastStep = 3'd0;
      isaPkg::OP_MUL, isaPkg::OP_DIV:                                  lastStep = 3'd3;
      default:                                                         lastStep = 3'd2;
    endcase
  end

  // T0 runs in the instrValid cycle itself
  assign busy       = instrValid | (state == EXEC);
  assign onLastStep = busy && (stepNum == lastStep);
  assign stepClear  = !busy | onLastStep;
  assign retire     = onLastStep;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state <= IDLE;
    end else if (onLastStep) begin
      state <= IDLE;
    end else if (instrValid) begin
      state <= EXEC;
    end
  end

  always_comb begin
    ctrl          = '0;
    ctrl.srcSel   = datapathPkg::SRC_REG0;
    ctrl.aluOp    = op;
    ctrl.constVal = {{(32 - isaPkg::CONST_WIDTH){instr.i.constant[isaPkg::CONST_WIDTH-1]}},
                     instr.i.constant};
    ctrl.rdInPort = !busy;  // in reads the word present at issue
    if (busy) begin
      case (op)
        isaPkg::OP_MFHI, isaPkg::OP_MFLO, isaPkg::OP_IN: begin
          ctrl.regIn = regSel(instr.r.rc);
          if (op == isaPkg::OP_MFHI) begin
            ctrl.srcSel = datapathPkg::SRC_HI;
          end else if (op == isaPkg::OP_MFLO) begin
            ctrl.srcSel = datapathPkg::SRC_LO;
          end else begin
            ctrl.srcSel = datapathPkg::SRC_INPORT;
          end
        end
        isaPkg::OP_OUT: begin
          ctrl.srcSel    = regSrc(instr.r.ra);
          ctrl.outPortIn = 1'b1;
        end
        default: begin
          case (stepNum)
            3'd0: begin
              ctrl.yIn    = 1'b1;
              ctrl.srcSel = regSrc(instr.r.ra);  // the I-format base rb shares these bits
              if (iForm) begin
                ctrl.baseZero = (instr.i.rb == 4'd0);
              end
            end
            3'd1: begin
              ctrl.zIn    = 1'b1;
              ctrl.srcSel = iForm ? datapathPkg::SRC_CONST : regSrc(instr.r.rb);
            end
            3'd2: begin
              ctrl.srcSel = datapathPkg::SRC_ZLOW;
              if (mulDiv) begin
                ctrl.loIn = 1'b1;
              end else begin
                ctrl.regIn = regSel(instr.r.rc);  // also the I-format ra
              end
            end
            default: begin
              ctrl.srcSel = datapathPkg::SRC_ZHIGH;  // mul/div only
              ctrl.hiIn   = 1'b1;
            end
          endcase
        end
      endcase
    end
  end

endmodule

/* logic/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
  input  logic                clock,
  input  logic                rstN,
  input  datapathPkg::apbReqT apbReq,
  output datapathPkg::apbRspT apbRsp
);

  datapathPkg::controlWordT ctrl;
  isaPkg::instrU            instr;
  logic                     instrValid;
  logic                     busy;
  logic                     stepClear;
  logic                     retire;
  logic [2:0]               stepNum;
  logic [15:0]              retiredCount;
  logic [31:0]              inPortData;
  logic [31:0]              outPortData;

  apbHostPort apbHostPort_inst (
    .clock        (clock),
    .rstN         (rstN),
    .apbReq       (apbReq),
    .apbRsp       (apbRsp),
    .busy         (busy),
    .retiredCount (retiredCount),
    .outPortData  (outPortData),
    .instrValid   (instrValid),
    .instr        (instr),
    .inPortData   (inPortData)
  );

  controlSequencer controlSequencer_inst (
    .clock      (clock),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .stepNum    (stepNum),
    .ctrl       (ctrl),
    .stepClear  (stepClear),
    .retire     (retire),
    .busy       (busy)
  );

  stepCounter stepCounter_inst (
    .clock        (clock),
    .rstN         (rstN),
    .stepClear    (stepClear),
    .retire       (retire),
    .stepNum      (stepNum),
    .retiredCount (retiredCount)
  );

  datapath datapath_inst (
    .clock       (clock),
    .rstN        (rstN),
    .ctrl        (ctrl),
    .inPortData  (inPortData),
    .outPortData (outPortData)
  );

endmodule

/* logic/datapath.sv */
`timescale 1ns/1ps

module datapath (
  input  logic                     clock,
  input  logic                     rstN,
  input  datapathPkg::controlWordT ctrl,
  input  logic [31:0]              inPortData,
  output logic [31:0]              outPortData
);

  logic [31:0] regOut [16];
  logic [31:0] hiOut;
  logic [31:0] loOut;
  logic [31:0] busOut;
  logic [31:0] yReg;
  logic [63:0] zReg;
  logic [63:0] aluResult;
  logic [31:0] inPortReg;

  registerBank registerBank_inst (
    .clock    (clock),
    .rstN     (rstN),
    .regIn    (ctrl.regIn),
    .hiIn     (ctrl.hiIn),
    .loIn     (ctrl.loIn),
    .baseZero (ctrl.baseZero),
    .busIn    (busOut),
    .regOut   (regOut),
    .hiOut    (hiOut),
    .loOut    (loOut)
  );

  alu alu_inst (
    .aluOp  (ctrl.aluOp),
    .yVal   (yReg),
    .busVal (busOut),
    .result (aluResult)
  );

  // single shared bus
  always_comb begin
    busOut = '0;
    if (ctrl.srcSel < datapathPkg::SRC_HI) begin
      busOut = regOut[ctrl.srcSel[3:0]];
    end else begin
      case (ctrl.srcSel)
        datapathPkg::SRC_HI:     busOut = hiOut;
        datapathPkg::SRC_LO:     busOut = loOut;
        datapathPkg::SRC_ZHIGH:  busOut = zReg[63:32];
        datapathPkg::SRC_ZLOW:   busOut = zReg[31:0];
        datapathPkg::SRC_INPORT: busOut = inPortReg;
        datapathPkg::SRC_CONST:  busOut = ctrl.constVal;
        default:                 busOut = '0;
      endcase
    end
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      yReg        <= '0;
      zReg        <= '0;
      inPortReg   <= '0;
      outPortData <= '0;
    end else begin
      if (ctrl.yIn) yReg <= busOut;
      if (ctrl.zIn) zReg <= aluResult;          // both halves at once
      if (ctrl.rdInPort) inPortReg <= inPortData;
      if (ctrl.outPortIn) outPortData <= busOut;
    end
  end

endmodule

/* logic/datapathPkg.sv */
package datapathPkg;

  // register n drives the bus under code n
  typedef enum logic [4:0] {
    SRC_REG0   = 5'd0,
    SRC_HI     = 5'd16,
    SRC_LO     = 5'd17,
    SRC_ZHIGH  = 5'd18,
    SRC_ZLOW   = 5'd19,
    SRC_INPORT = 5'd20,
    SRC_CONST  = 5'd21
  } busSrcE;

  typedef struct packed {
    logic [15:0]    regIn;
    logic           hiIn;
    logic           loIn;
    logic           yIn;
    logic           zIn;
    logic           outPortIn;
    logic           rdInPort;
    logic           baseZero;   // R0 reads as zero
    busSrcE         srcSel;
    isaPkg::opcodeE aluOp;
    logic [31:0]    constVal;   // already sign extended
  } controlWordT;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apbReqT;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apbRspT;

  localparam logic [3:0] ADDR_INSTR   = 4'h0;
  localparam logic [3:0] ADDR_INPORT  = 4'h4;
  localparam logic [3:0] ADDR_OUTPORT = 4'h8;
  localparam logic [3:0] ADDR_STATUS  = 4'hC;

endpackage

/* logic/isaPkg.sv */
package isaPkg;

  // 5-bit opcode, top of every instruction word
  typedef enum logic [4:0] {
    OP_ADD  = 5'd0,
    OP_SUB  = 5'd1,
    OP_AND  = 5'd2,
    OP_OR   = 5'd3,
    OP_SHL  = 5'd4,
    OP_SHR  = 5'd5,
    OP_MUL  = 5'd6,
    OP_DIV  = 5'd7,
    OP_ADDI = 5'd8,
    OP_ANDI = 5'd9,
    OP_ORI  = 5'd10,
    OP_MFHI = 5'd11,
    OP_MFLO = 5'd12,
    OP_IN   = 5'd13,
    OP_OUT  = 5'd14
  } opcodeE;

  localparam int CONST_WIDTH = 19;

  // alu ops write rc from ra, rb
  // mfhi, mflo and in write rc, out sends ra to the output port
  typedef struct packed {
    opcodeE      opcode;
    logic [3:0]  rc;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [14:0] unused;
  } rFormatT;

  // ra gets rb combined with the sign-extended constant
  typedef struct packed {
    opcodeE                   opcode;
    logic [3:0]               ra;
    logic [3:0]               rb;
    logic [CONST_WIDTH-1:0]   constant;
  } iFormatT;

  typedef union packed {
    rFormatT r;
    iFormatT i;
  } instrU;

  function automatic logic isIFormat(input opcodeE op);
    return op inside {OP_ADDI, OP_ANDI, OP_ORI};
  endfunction

endpackage

/* logic/registerBank.sv */
`timescale 1ns/1ps

module registerBank (
  input  logic        clock,
  input  logic        rstN,
  input  logic [15:0] regIn,
  input  logic        hiIn,
  input  logic        loIn,
  input  logic        baseZero,
  input  logic [31:0] busIn,
  output logic [31:0] regOut [16],
  output logic [31:0] hiOut,
  output logic [31:0] loOut
);

  logic [31:0] regs [16];

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
      hiOut <= '0;
      loOut <= '0;
    end else begin
      for (int i = 0; i < 16; i++) begin
        if (regIn[i]) begin
          regs[i] <= busIn;
        end
      end
      if (hiIn) begin
        hiOut <= busIn;
      end
      if (loIn) begin
        loOut <= busIn;
      end
    end
  end

  always_comb begin
    regOut = regs;
    if (baseZero) begin
      regOut[0] = '0;  // base of an I-format op
    end
  end

endmodule

/* logic/stepCounter.sv */
`timescale 1ns/1ps

module stepCounter (
  input  logic        clock,
  input  logic        rstN,
  input  logic        stepClear,
  input  logic        retire,
  output logic [2:0]  stepNum,
  output logic [15:0] retiredCount
);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      stepNum      <= '0;
      retiredCount <= '0;
    end else begin
      if (stepClear) begin
        stepNum <= '0;  // held while idle
      end else begin
        stepNum <= stepNum + 3'd1;
      end
      if (retire) retiredCount <= retiredCount + 16'd1;  // wraps
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the cpuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module cpuCoreTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/VcpuCoreTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qF "*** PASSED ***" sim.log; then
  exit 0
fi
exit 1

/* tests/refModel.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// architectural state as the host should see it
logic [31:0] refRegs [16];
logic [31:0] refHi;
logic [31:0] refLo;
logic [31:0] refInPort;
logic [31:0] refOutPort;

function automatic void clearModel();
  for (int i = 0; i < 16; i++) begin
    refRegs[i] = '0;
  end
  refHi      = '0;
  refLo      = '0;
  refInPort  = '0;
  refOutPort = '0;
endfunction

function automatic logic [63:0] predictAlu(input isaPkg::opcodeE op, input logic [31:0] a,
                                           input logic [31:0] b);
  logic signed [63:0] wideA;
  logic signed [63:0] wideB;
  logic signed [31:0] numer;
  logic signed [31:0] denom;
  logic [63:0]        res;
  wideA = {{32{a[31]}}, a};
  wideB = {{32{b[31]}}, b};
  numer = a;
  denom = b;
  res   = '0;
  case (op)
    isaPkg::OP_ADD, isaPkg::OP_ADDI: res[31:0] = a + b;
    isaPkg::OP_SUB:                  res[31:0] = a - b;
    isaPkg::OP_AND, isaPkg::OP_ANDI: res[31:0] = a & b;
    isaPkg::OP_OR, isaPkg::OP_ORI:   res[31:0] = a | b;
    isaPkg::OP_SHL:                  res[31:0] = a << b[4:0];
    isaPkg::OP_SHR:                  res[31:0] = a >> b[4:0];
    isaPkg::OP_MUL:                  res = wideA * wideB;
    isaPkg::OP_DIV: begin
      if (b == '0) begin
        res = {a, 32'hFFFF_FFFF};  // remainder is the dividend
      end else if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
        res = {32'h0, a};  // quotient wraps modulo 2^32
      end else begin
        res = {numer % denom, numer / denom};
      end
    end
    default: res = '0;
  endcase
  return res;
endfunction

function automatic void applyInstr(input logic [31:0] word);
  isaPkg::opcodeE op;
  logic [3:0]     dest;   // rc, or ra in the I view
  logic [3:0]     srcA;   // ra, or the base in the I view
  logic [3:0]     srcB;
  logic [31:0]    base;
  logic [63:0]    res;
  op   = isaPkg::opcodeE'(word[31:27]);
  dest = word[26:23];
  srcA = word[22:19];
  srcB = word[18:15];
  case (op)
    isaPkg::OP_ADDI, isaPkg::OP_ANDI, isaPkg::OP_ORI: begin
      base          = (srcA == 4'd0) ? '0 : refRegs[srcA];  // R0 base is zero
      res           = predictAlu(op, base, {{13{word[18]}}, word[18:0]});
      refRegs[dest] = res[31:0];
    end
    isaPkg::OP_MUL, isaPkg::OP_DIV: begin
      res   = predictAlu(op, refRegs[srcA], refRegs[srcB]);
      refLo = res[31:0];
      refHi = res[63:32];
    end
    isaPkg::OP_MFHI: refRegs[dest] = refHi;
    isaPkg::OP_MFLO: refRegs[dest] = refLo;
    isaPkg::OP_IN:   refRegs[dest] = refInPort;
    isaPkg::OP_OUT:  refOutPort = refRegs[srcA];
    default: begin
      res           = predictAlu(op, refRegs[srcA], refRegs[srcB]);
      refRegs[dest] = res[31:0];
    end
  endcase
endfunction

`endif

/* tests/cpuCoreTb.sv */
`timescale 1ns/1ps

module cpuCoreTb;

  localparam int CLOCK_PERIOD     = 100;
  localparam int DRIVE_DELAY      = 1;
  localparam int SEED             = 60633;
  localparam int RANDOM_INSTRS    = 150;
  localparam int MAX_INSTRS       = 200;
  localparam int CYCLES_PER_INSTR = 12;
  localparam int CYCLE_LIMIT      = MAX_INSTRS * CYCLES_PER_INSTR + 200;
  localparam int MUL_STEPS        = 4;

  logic                clock;
  logic                rstN;
  datapathPkg::apbReqT apbReq;
  datapathPkg::apbRspT apbRsp;
  int                  cycleCount;
  int                  doneCycle;  // cycle of the last completed transfer
  int                  issued;

  `include "refModel.svh"

  cpuCore cpuCore_inst (
    .clock  (clock),
    .rstN   (rstN),
    .apbReq (apbReq),
    .apbRsp (apbRsp)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(CLOCK_PERIOD / 2);
      clock = ~clock;
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < CYCLE_LIMIT) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("*** FAILED ***");
    $fatal(1);
  end

  function automatic logic [31:0] encodeR(input isaPkg::opcodeE op, input logic [3:0] rc,
                                          input logic [3:0] ra, input logic [3:0] rb);
    return {op, rc, ra, rb, 15'd0};
  endfunction

  function automatic logic [31:0] encodeI(input isaPkg::opcodeE op, input logic [3:0] ra,
                                          input logic [3:0] rb, input logic [18:0] c);
    return {op, ra, rb, c};
  endfunction

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %h actual %h", testName, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  // called 1 ns after a rising edge, returns at the same offset
  task automatic apbTransfer(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic slvErr);
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite  = write;
    apbReq.paddr   = addr;
    apbReq.pwdata  = wdata;
    @(posedge clock);
    #DRIVE_DELAY;
    apbReq.penable = 1'b1;
    @(negedge clock);
    while (!apbRsp.pready) begin
      @(negedge clock);  // stalled access
    end
    rdata     = apbRsp.prdata;
    slvErr    = apbRsp.pslverr;
    doneCycle = cycleCount;
    @(posedge clock);
    #DRIVE_DELAY;
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  task automatic issue(input logic [31:0] word);
    logic [31:0] data;
    logic        err;
    apbTransfer(1'b1, datapathPkg::ADDR_INSTR, word, data, err);
    checkValue("instr write pslverr", 32'd0, {31'd0, err});
    applyInstr(word);
    issued++;
  endtask

  task automatic waitIdle();
    logic [31:0] status;
    logic        err;
    status = 32'h1;
    while (status[0]) begin
      apbTransfer(1'b0, datapathPkg::ADDR_STATUS, '0, status, err);
    end
  endtask

  task automatic loadWord(input logic [3:0] dest, input logic [31:0] value);
    logic [31:0] data;
    logic        err;
    apbTransfer(1'b1, datapathPkg::ADDR_INPORT, value, data, err);
    checkValue("inport write pslverr", 32'd0, {31'd0, err});
    refInPort = value;
    issue(encodeR(isaPkg::OP_IN, dest, 4'd0, 4'd0));
  endtask

  task automatic checkOut(input string testName, input logic [3:0] src);
    logic [31:0] data;
    logic        err;
    issue(encodeR(isaPkg::OP_OUT, 4'd0, src, 4'd0));
    waitIdle();
    apbTransfer(1'b0, datapathPkg::ADDR_OUTPORT, '0, data, err);
    checkValue("outport read pslverr", 32'd0, {31'd0, err});
    checkValue(testName, refOutPort, data);
  endtask

  initial begin
    logic [31:0]    data;
    logic           err;
    logic [31:0]    a;
    logic [31:0]    b;
    logic [18:0]    cVal;
    logic [3:0]     rc;
    logic [3:0]     ra;
    logic [3:0]     rb;
    int unsigned    opSel;
    int             firstDone;
    isaPkg::opcodeE op;
    rstN   = 1'b0;
    apbReq = '0;
    issued = 0;
    void'($urandom(SEED));
    clearModel();
    repeat (2) @(posedge clock);
    #DRIVE_DELAY;
    rstN = 1'b1;

    apbTransfer(1'b0, datapathPkg::ADDR_STATUS, '0, data, err);
    checkValue("reset status", 32'd0, data);
    apbTransfer(1'b0, datapathPkg::ADDR_OUTPORT, '0, data, err);
    checkValue("reset outport", 32'd0, data);

    // random program, every register loaded first
    for (int r = 0; r < 16; r++) begin
      loadWord(4'(r), $urandom);
    end
    for (int n = 16; n < RANDOM_INSTRS; n++) begin
      opSel = $urandom_range(0, 15);
      rc    = 4'($urandom_range(0, 15));
      ra    = 4'($urandom_range(0, 15));
      rb    = 4'($urandom_range(0, 15));
      cVal  = 19'($urandom);
      op    = (opSel == 15) ? isaPkg::OP_OUT : isaPkg::opcodeE'(opSel[4:0]);  // extra weight on out
      case (op)
        isaPkg::OP_IN:                                    loadWord(rc, $urandom);
        isaPkg::OP_OUT:                                   checkOut("random out", ra);
        isaPkg::OP_ADDI, isaPkg::OP_ANDI, isaPkg::OP_ORI: issue(encodeI(op, ra, rb, cVal));
        default:                                          issue(encodeR(op, rc, ra, rb));
      endcase
    end

    // mul and div through HI/LO, last pair divides by zero
    for (int pair = 0; pair < 3; pair++) begin
      a = $urandom;
      b = $urandom_range(1, 255);
      if (pair == 0) begin
        b = $urandom;
      end else if (pair == 1 && a[0]) begin
        b = ~b + 32'd1;  // small negative divisor
      end else if (pair == 2) begin
        b = '0;
      end
      loadWord(4'd1, a);
      loadWord(4'd2, b);
      for (int k = 0; k < 2; k++) begin
        op = (k == 0) ? isaPkg::OP_MUL : isaPkg::OP_DIV;
        issue(encodeR(op, 4'd0, 4'd1, 4'd2));
        apbTransfer(1'b0, datapathPkg::ADDR_STATUS, '0, data, err);
        checkValue($sformatf("%s busy", op.name()), 32'd1, {31'd0, data[0]});
        issue(encodeR(isaPkg::OP_MFHI, 4'd3, 4'd0, 4'd0));
        checkOut($sformatf("%s hi", op.name()), 4'd3);
        issue(encodeR(isaPkg::OP_MFLO, 4'd4, 4'd0, 4'd0));
        checkOut($sformatf("%s lo", op.name()), 4'd4);
      end
    end

    // second write waits out the whole mul
    issue(encodeR(isaPkg::OP_MUL, 4'd0, 4'd5, 4'd6));
    firstDone = doneCycle;
    issue(encodeR(isaPkg::OP_MFLO, 4'd7, 4'd0, 4'd0));
    checkValue("back-pressure stall", 32'(MUL_STEPS + 1), 32'(doneCycle - firstDone));
    checkOut("back-pressure order", 4'd7);

    apbTransfer(1'b0, datapathPkg::ADDR_INSTR, '0, data, err);
    checkValue("read of instr register", 32'd1, {31'd0, err});
    apbTransfer(1'b1, datapathPkg::ADDR_STATUS, $urandom, data, err);
    checkValue("write of status register", 32'd1, {31'd0, err});
    apbTransfer(1'b0, 4'h2, '0, data, err);
    checkValue("unused address", 32'd1, {31'd0, err});

    // R0 holds data but reads as zero as an I-format base
    loadWord(4'd0, $urandom | 32'h1);
    cVal = 19'($urandom) | 19'h4_0000;
    issue(encodeI(isaPkg::OP_ADDI, 4'd9, 4'd0, cVal));
    checkOut("addi with R0 base", 4'd9);
    checkOut("R0 contents", 4'd0);

    waitIdle();
    apbTransfer(1'b0, datapathPkg::ADDR_STATUS, '0, data, err);
    checkValue("retired count", 32'(issued), {16'd0, data[31:16]});

    $display("*** PASSED ***");
    $finish;
  end

endmodule
